//--- verilog.f
+incdir+.
rn_pkg.sv
rn_ring_ptr.sv
rn_ctrl.sv
rn_rat.sv
rn_free_list.sv
rn_top.sv
rn_properties.sv
tb_rn_checker.sv
tb_rn_top.sv

//--- Bender.yml
package:
  name: rn_stage

sources:
  - include_dirs:
      - .
    files:
      - rn_pkg.sv
      - rn_ring_ptr.sv
      - rn_ctrl.sv
      - rn_rat.sv
      - rn_free_list.sv
      - rn_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rn_properties.sv
      - tb_rn_checker.sv
      - tb_rn_top.sv

//--- tb_rn_top.sv
// Testbench for the rename stage, playing front end and ROB with random traffic
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module tb_rn_top;

   localparam int STIM_CYCLES    = 3000;
   localparam int TIMEOUT_CYCLES = STIM_CYCLES + 1000;

   logic                       clk;
   logic                       rst;
   logic                       flush;
   logic [`RN_IW-1:0]          rn_valid;
   rn_pkg::lreg_t [`RN_IW-1:0] lrs1;
   rn_pkg::lreg_t [`RN_IW-1:0] lrs2;
   rn_pkg::lreg_t [`RN_IW-1:0] lrd;
   logic [`RN_IW-1:0]          lrd_we;
   logic                       rn_ready;
   rn_pkg::preg_t [`RN_IW-1:0] prs1;
   rn_pkg::preg_t [`RN_IW-1:0] prs2;
   rn_pkg::preg_t [`RN_IW-1:0] prd;
   rn_pkg::preg_t [`RN_IW-1:0] pfree;
   logic [`RN_CW-1:0]          cmt_fire;
   logic [`RN_CW-1:0]          cmt_prd_we;
   rn_pkg::lreg_t [`RN_CW-1:0] cmt_lrd;
   rn_pkg::preg_t [`RN_CW-1:0] cmt_prd;
   rn_pkg::preg_t [`RN_CW-1:0] cmt_pfree;

   // ROB entry {lrd_we, lrd, prd, pfree}
   logic [17:0] rob_q [$];
   logic        last_fire;
   integer      seed;
   int          cycle_count = 0;
   int          error_count;
   int          check_count;

   rn_top u_dut
   (
      .clk        (clk),
      .rst        (rst),
      .flush      (flush),
      .rn_valid   (rn_valid),
      .lrs1       (lrs1),
      .lrs2       (lrs2),
      .lrd        (lrd),
      .lrd_we     (lrd_we),
      .rn_ready   (rn_ready),
      .prs1       (prs1),
      .prs2       (prs2),
      .prd        (prd),
      .pfree      (pfree),
      .cmt_fire   (cmt_fire),
      .cmt_lrd    (cmt_lrd),
      .cmt_prd    (cmt_prd),
      .cmt_pfree  (cmt_pfree),
      .cmt_prd_we (cmt_prd_we)
   );

   tb_rn_checker u_checker
   (
      .clk         (clk),
      .rst         (rst),
      .flush       (flush),
      .rn_valid    (rn_valid),
      .lrs1        (lrs1),
      .lrs2        (lrs2),
      .lrd         (lrd),
      .lrd_we      (lrd_we),
      .rn_ready    (rn_ready),
      .prs1        (prs1),
      .prs2        (prs2),
      .prd         (prd),
      .pfree       (pfree),
      .cmt_fire    (cmt_fire),
      .cmt_prd_we  (cmt_prd_we),
      .cmt_lrd     (cmt_lrd),
      .cmt_prd     (cmt_prd),
      .cmt_pfree   (cmt_pfree),
      .error_count (error_count),
      .check_count (check_count)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Half the picks come from a narrow range so slots of a group collide
   function automatic rn_pkg::lreg_t pick_reg();
      logic [31:0] r;
      r = $random(seed);
      return r[31] ? {2'b00, r[2:0]} : r[4:0];
   endfunction

   task automatic new_group();
      logic [31:0] r;
      r = $random(seed);
      for (int i = 0; i < `RN_IW; i++)
      begin
         rn_valid[i] = (i < (r[7:0] % (`RN_IW + 1)));
         lrs1[i]     = pick_reg();
         lrs2[i]     = pick_reg();
         lrd[i]      = pick_reg();
         lrd_we[i]   = (r[9 + 2*i +: 2] != 2'b00);
      end
   endtask

   // Retire up to n of the oldest entries in order
   task automatic retire(input int n);
      logic [17:0] e;
      cmt_fire   = '0;
      cmt_prd_we = '0;
      cmt_lrd    = '0;
      cmt_prd    = '0;
      cmt_pfree  = '0;
      for (int k = 0; k < `RN_CW; k++)
      begin
         if ((k < n) && (rob_q.size() > 0))
         begin
            e             = rob_q.pop_front();
            cmt_fire[k]   = 1'b1;
            cmt_prd_we[k] = e[17];
            cmt_lrd[k]    = e[16:12];
            cmt_prd[k]    = e[11:6];
            cmt_pfree[k]  = e[5:0];
         end
      end
   endtask

   // ROB allocation for every slot that fires at this edge
   always @(posedge clk)
   begin
      if (rst)
      begin
         rob_q.delete();
         last_fire = 1'b0;
      end
      else
      begin
         last_fire = rn_ready;
         for (int i = 0; i < `RN_IW; i++)
         begin
            if (rn_valid[i] && rn_ready)
               rob_q.push_back({lrd_we[i], lrd[i], prd[i], pfree[i]});
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   initial
   begin
      logic [31:0] r;
      int          n_cmt;
      seed     = 32'h1447;
      rst      = 1'b1;
      flush    = 1'b0;
      rn_valid = '0;
      lrs1     = '0;
      lrs2     = '0;
      lrd      = '0;
      lrd_we   = '0;
      retire(0);
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int c = 0; c < STIM_CYCLES; c++)
      begin
         @(negedge clk);
         r = $random(seed);
         // Slow retirement drains the free list, fast retirement refills it
         if (((c / 250) % 2) == 0)
            n_cmt = (r[2:0] == 3'd0) ? 1 : 0;
         else
            n_cmt = r[4:3];
         retire(n_cmt);
         // Older entries may still retire in the recovery cycle before the queue empties
         if (flush)
            rob_q.delete();
         flush = (r[12:6] == 7'd0) && (c > 20);
         // Front end holds a group that was not accepted
         if ((rn_valid == '0) || last_fire)
            new_group();
      end
      @(negedge clk);
      flush    = 1'b0;
      rn_valid = '0;
      retire(0);
      repeat (4) @(negedge clk);
      $display("checks %0d, errors %0d, assertion failures %0d",
               check_count, error_count, u_dut.u_ctrl.u_props.fail_count);
      if ((error_count == 0) && (check_count > 0) && (u_dut.u_ctrl.u_props.fail_count == 0))
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb_rn_checker.sv
// Reference model of the rename stage that compares the DUT outputs every cycle
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module tb_rn_checker
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         flush,
   input  logic [`RN_IW-1:0]            rn_valid,
   input  rn_pkg::lreg_t [`RN_IW-1:0]   lrs1,
   input  rn_pkg::lreg_t [`RN_IW-1:0]   lrs2,
   input  rn_pkg::lreg_t [`RN_IW-1:0]   lrd,
   input  logic [`RN_IW-1:0]            lrd_we,
   input  logic                         rn_ready,
   input  rn_pkg::preg_t [`RN_IW-1:0]   prs1,
   input  rn_pkg::preg_t [`RN_IW-1:0]   prs2,
   input  rn_pkg::preg_t [`RN_IW-1:0]   prd,
   input  rn_pkg::preg_t [`RN_IW-1:0]   pfree,
   input  logic [`RN_CW-1:0]            cmt_fire,
   input  logic [`RN_CW-1:0]            cmt_prd_we,
   input  rn_pkg::lreg_t [`RN_CW-1:0]   cmt_lrd,
   input  rn_pkg::preg_t [`RN_CW-1:0]   cmt_prd,
   input  rn_pkg::preg_t [`RN_CW-1:0]   cmt_pfree,
   output int                           error_count,
   output int                           check_count
);

   localparam int N_LRF    = 1 << `RN_LRF_AW;
   localparam int FL_DEPTH = 1 << `RN_FL_AW;

   rn_pkg::preg_t spec_map [N_LRF];
   rn_pkg::preg_t arch_map [N_LRF];
   // Free registers from the oldest uncommitted allocation to the last return
   rn_pkg::preg_t free_q [$];
   // Entries of free_q handed out but not yet committed
   int            spec_off;
   logic          in_recover;

   initial
   begin
      error_count = 0;
      check_count = 0;
   end

   // Expected {prs1, prs2, prd, pfree} of one slot of the group on the inputs
   function automatic logic [23:0] predict_slot(input int i);
      rn_pkg::preg_t e_prs1;
      rn_pkg::preg_t e_prs2;
      rn_pkg::preg_t e_prd;
      rn_pkg::preg_t e_pfree;
      int            idx;
      idx     = spec_off;
      e_prs1  = spec_map[lrs1[i]];
      e_prs2  = spec_map[lrs2[i]];
      e_pfree = spec_map[lrd[i]];
      // Older writers of the group, the youngest of them last
      for (int k = 0; k < i; k++)
      begin
         if (lrd_we[k])
         begin
            if (lrs1[i] == lrd[k])
               e_prs1 = free_q[idx];
            if (lrs2[i] == lrd[k])
               e_prs2 = free_q[idx];
            if (lrd_we[i] && (lrd[i] == lrd[k]))
               e_pfree = free_q[idx];
            idx++;
         end
      end
      e_prd = (idx < free_q.size()) ? free_q[idx] : '0;
      return {e_prs1, e_prs2, e_prd, e_pfree};
   endfunction

   task automatic compare_field(input string name, input int slot, input int got,
                                input int exp_v);
      check_count++;
      if (got != exp_v)
      begin
         error_count++;
         $display("error %0t: %s slot %0d got %0d expected %0d",
                  $time, name, slot, got, exp_v);
      end
   endtask

   always @(posedge clk)
   begin
      logic [23:0] preds [`RN_IW];
      logic        exp_ready;
      int          n_alloc;
      if (rst)
      begin
         free_q.delete();
         for (int i = 0; i < N_LRF; i++)
         begin
            spec_map[i] = rn_pkg::preg_t'(i);
            arch_map[i] = rn_pkg::preg_t'(i);
         end
         for (int i = 0; i < FL_DEPTH; i++)
            free_q.push_back(rn_pkg::preg_t'(i + N_LRF));
         spec_off   = 0;
         in_recover = 1'b0;
      end
      else
      begin
         exp_ready = !in_recover && !flush && ((free_q.size() - spec_off) >= `RN_IW);
         compare_field("rn_ready", 0, rn_ready, exp_ready);
         for (int i = 0; i < `RN_IW; i++)
         begin
            preds[i] = predict_slot(i);
            if (rn_valid[i] && rn_ready)
            begin
               compare_field("prs1", i, prs1[i], preds[i][23:18]);
               compare_field("prs2", i, prs2[i], preds[i][17:12]);
               compare_field("pfree", i, pfree[i], preds[i][5:0]);
               if (lrd_we[i])
                  compare_field("prd", i, prd[i], preds[i][11:6]);
            end
         end
         // Renames land in the speculative map, later slot last
         n_alloc = 0;
         for (int i = 0; i < `RN_IW; i++)
         begin
            if (rn_valid[i] && rn_ready && lrd_we[i])
            begin
               spec_map[lrd[i]] = preds[i][11:6];
               n_alloc++;
            end
         end
         spec_off = spec_off + n_alloc;
         for (int k = 0; k < `RN_CW; k++)
         begin
            if (cmt_fire[k] && cmt_prd_we[k])
            begin
               arch_map[cmt_lrd[k]] = cmt_prd[k];
               free_q.push_back(cmt_pfree[k]);
               void'(free_q.pop_front());
               spec_off--;
            end
         end
         // Recovery restores the committed view, commits of this cycle included
         if (in_recover)
         begin
            spec_map = arch_map;
            spec_off = 0;
         end
         in_recover = flush;
      end
   end

endmodule

`default_nettype wire

//--- rn_properties.sv
// Concurrent checks on the rename handshake, the recovery pulse and free-list occupancy
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module rn_properties
(
   input logic                 clk,
   input logic                 rst,
   input logic                 flush,
   input logic                 rn_ready,
   input logic [`RN_IW-1:0]    rn_we,
   input logic                 rollback,
   input logic [`RN_FL_AW:0]   fl_count
);

   localparam logic [`RN_FL_AW:0] FL_DEPTH = 1 << `RN_FL_AW;

   // Failures seen so far, read by the testbench at the end of the run
   int fail_count = 0;

   a_we_gated: assert property (@(posedge clk) disable iff (rst)
      !rn_ready |-> (rn_we == '0))
   else
   begin
      $error("rn_we is active while rn_ready is low");
      fail_count++;
   end

   a_flush_rollback: assert property (@(posedge clk) disable iff (rst)
      flush |=> rollback)
   else
   begin
      $error("rollback did not follow a flush");
      fail_count++;
   end

   a_rollback_len: assert property (@(posedge clk) disable iff (rst)
      (rollback && !flush) |=> !rollback)
   else
   begin
      $error("rollback lasted longer than one cycle");
      fail_count++;
   end

   a_fl_count: assert property (@(posedge clk) disable iff (rst)
      fl_count <= FL_DEPTH)
   else
   begin
      $error("free-list count above its depth");
      fail_count++;
   end

endmodule

// fl_count reaches the controller from the free list, so one bind covers both blocks
bind rn_ctrl rn_properties u_props
(
   .clk      (clk),
   .rst      (rst),
   .flush    (flush),
   .rn_ready (rn_ready),
   .rn_we    (rn_we),
   .rollback (rollback),
   .fl_count (fl_count)
);

`default_nettype wire

//--- rn_top.sv
// Register-rename stage top joining the controller, the alias tables and the free list
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module rn_top
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         flush,
   // Front end
   input  logic [`RN_IW-1:0]            rn_valid,
   input  rn_pkg::lreg_t [`RN_IW-1:0]   lrs1,
   input  rn_pkg::lreg_t [`RN_IW-1:0]   lrs2,
   input  rn_pkg::lreg_t [`RN_IW-1:0]   lrd,
   input  logic [`RN_IW-1:0]            lrd_we,
   output logic                         rn_ready,
   output rn_pkg::preg_t [`RN_IW-1:0]   prs1,
   output rn_pkg::preg_t [`RN_IW-1:0]   prs2,
   output rn_pkg::preg_t [`RN_IW-1:0]   prd,
   output rn_pkg::preg_t [`RN_IW-1:0]   pfree,
   // ROB commit
   input  logic [`RN_CW-1:0]            cmt_fire,
   input  rn_pkg::lreg_t [`RN_CW-1:0]   cmt_lrd,
   input  rn_pkg::preg_t [`RN_CW-1:0]   cmt_prd,
   input  rn_pkg::preg_t [`RN_CW-1:0]   cmt_pfree,
   input  logic [`RN_CW-1:0]            cmt_prd_we
);

   logic [`RN_IW-1:0]          rn_we;
   logic                       rollback;
   logic [`RN_FL_AW:0]         fl_count;
   rn_pkg::preg_t [`RN_IW-1:0] fl_prd;

   assign prd = fl_prd;

   rn_ctrl u_ctrl
   (
      .clk      (clk),
      .rst      (rst),
      .flush    (flush),
      .rn_valid (rn_valid),
      .fl_count (fl_count),
      .rn_ready (rn_ready),
      .rn_we    (rn_we),
      .rollback (rollback)
   );

   rn_rat u_rat
   (
      .clk        (clk),
      .rst        (rst),
      .rn_we      (rn_we),
      .rollback   (rollback),
      .lrs1       (lrs1),
      .lrs2       (lrs2),
      .lrd        (lrd),
      .lrd_we     (lrd_we),
      .fl_prd     (fl_prd),
      .prs1       (prs1),
      .prs2       (prs2),
      .pfree      (pfree),
      .cmt_fire   (cmt_fire),
      .cmt_prd_we (cmt_prd_we),
      .cmt_lrd    (cmt_lrd),
      .cmt_prd    (cmt_prd)
   );

   rn_free_list u_free_list
   (
      .clk        (clk),
      .rst        (rst),
      .rn_we      (rn_we),
      .lrd_we     (lrd_we),
      .rollback   (rollback),
      .fl_prd     (fl_prd),
      .fl_count   (fl_count),
      .cmt_fire   (cmt_fire),
      .cmt_prd_we (cmt_prd_we),
      .cmt_pfree  (cmt_pfree)
   );

endmodule

`default_nettype wire

//--- rn_free_list.sv
// Circular free list of physical registers with speculative head, commit head and tail
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module rn_free_list
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic [`RN_IW-1:0]            rn_we,
   input  logic [`RN_IW-1:0]            lrd_we,
   input  logic                         rollback,
   output rn_pkg::preg_t [`RN_IW-1:0]   fl_prd,
   output logic [`RN_FL_AW:0]           fl_count,
   input  logic [`RN_CW-1:0]            cmt_fire,
   input  logic [`RN_CW-1:0]            cmt_prd_we,
   input  rn_pkg::preg_t [`RN_CW-1:0]   cmt_pfree
);

   localparam int FL_DEPTH = 1 << `RN_FL_AW;

   rn_pkg::preg_t        fl_mem [FL_DEPTH];
   rn_pkg::fl_ptr_t      spec_head;
   rn_pkg::fl_ptr_t      cmt_head;
   rn_pkg::fl_ptr_t      cmt_head_nxt;
   rn_pkg::fl_ptr_t      tail;
   logic [`RN_IW:0]      alloc_cnt;
   logic [`RN_IW:0]      cmt_cnt;
   logic [`RN_FL_AW-1:0] rd_addr [`RN_IW];
   logic [`RN_FL_AW-1:0] wr_addr [`RN_CW];

   // Compacted allocation, each writing slot takes the next entry
   always_comb
   begin
      logic [`RN_IW:0] off;
      off       = '0;
      alloc_cnt = '0;
      for (int k = 0; k < `RN_IW; k++)
      begin
         rd_addr[k] = spec_head[`RN_FL_AW-1:0] + `RN_FL_AW'(off);
         fl_prd[k]  = fl_mem[rd_addr[k]];
         if (lrd_we[k])
            off = off + 1'b1;
         if (rn_we[k] && lrd_we[k])
            alloc_cnt = alloc_cnt + 1'b1;
      end
   end

   // Returned registers are packed at the tail
   always_comb
   begin
      cmt_cnt = '0;
      for (int k = 0; k < `RN_CW; k++)
      begin
         wr_addr[k] = tail[`RN_FL_AW-1:0] + `RN_FL_AW'(cmt_cnt);
         if (cmt_fire[k] && cmt_prd_we[k])
            cmt_cnt = cmt_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         // List starts full with the registers above the logical ones
         for (int i = 0; i < FL_DEPTH; i++)
            fl_mem[i] <= rn_pkg::preg_t'(i + FL_DEPTH);
      end
      else
      begin
         for (int k = 0; k < `RN_CW; k++)
         begin
            if (cmt_fire[k] && cmt_prd_we[k])
               fl_mem[wr_addr[k]] <= cmt_pfree[k];
         end
      end
   end

   assign cmt_head_nxt = cmt_head + rn_pkg::fl_ptr_t'(cmt_cnt);

   // Tail wrap bit reads inverted since the list begins full
   assign fl_count = {~tail[`RN_FL_AW], tail[`RN_FL_AW-1:0]} - spec_head;

   rn_ring_ptr u_spec_head
   (
      .clk        (clk),
      .rst        (rst),
      .step       (alloc_cnt),
      .load       (rollback),
      .load_value (cmt_head_nxt),
      .ptr        (spec_head)
   );

   rn_ring_ptr u_cmt_head
   (
      .clk        (clk),
      .rst        (rst),
      .step       (cmt_cnt),
      .load       (1'b0),
      .load_value ('0),
      .ptr        (cmt_head)
   );

   rn_ring_ptr u_tail
   (
      .clk        (clk),
      .rst        (rst),
      .step       (cmt_cnt),
      .load       (1'b0),
      .load_value ('0),
      .ptr        (tail)
   );

endmodule

`default_nettype wire

//--- rn_rat.sv
// Speculative and architectural register alias tables with rollback and group bypass
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module rn_rat
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic [`RN_IW-1:0]            rn_we,
   input  logic                         rollback,
   input  rn_pkg::lreg_t [`RN_IW-1:0]   lrs1,
   input  rn_pkg::lreg_t [`RN_IW-1:0]   lrs2,
   input  rn_pkg::lreg_t [`RN_IW-1:0]   lrd,
   input  logic [`RN_IW-1:0]            lrd_we,
   // New registers from the free list
   input  rn_pkg::preg_t [`RN_IW-1:0]   fl_prd,
   output rn_pkg::preg_t [`RN_IW-1:0]   prs1,
   output rn_pkg::preg_t [`RN_IW-1:0]   prs2,
   output rn_pkg::preg_t [`RN_IW-1:0]   pfree,
   // Commit side
   input  logic [`RN_CW-1:0]            cmt_fire,
   input  logic [`RN_CW-1:0]            cmt_prd_we,
   input  rn_pkg::lreg_t [`RN_CW-1:0]   cmt_lrd,
   input  rn_pkg::preg_t [`RN_CW-1:0]   cmt_prd
);

   localparam int N_LRF = 1 << `RN_LRF_AW;

   rn_pkg::preg_t rat_q  [N_LRF];
   rn_pkg::preg_t rat_d  [N_LRF];
   rn_pkg::preg_t arat_q [N_LRF];
   rn_pkg::preg_t arat_d [N_LRF];

   // Architectural table follows commits, later slot wins
   always_comb
   begin
      arat_d = arat_q;
      for (int k = 0; k < `RN_CW; k++)
      begin
         if (cmt_fire[k] && cmt_prd_we[k])
            arat_d[cmt_lrd[k]] = cmt_prd[k];
      end
   end

   // Speculative table takes the renamed group, or the committed map on rollback
   always_comb
   begin
      rat_d = rat_q;
      if (rollback)
      begin
         rat_d = arat_d;
      end
      else
      begin
         for (int k = 0; k < `RN_IW; k++)
         begin
            if (rn_we[k] && lrd_we[k])
               rat_d[lrd[k]] = fl_prd[k];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         // Identity map out of reset
         for (int i = 0; i < N_LRF; i++)
         begin
            rat_q[i]  <= rn_pkg::preg_t'(i);
            arat_q[i] <= rn_pkg::preg_t'(i);
         end
      end
      else
      begin
         rat_q  <= rat_d;
         arat_q <= arat_d;
      end
   end

   // Table read, then override by older slots of the same group
   always_comb
   begin
      for (int i = 0; i < `RN_IW; i++)
      begin
         prs1[i]  = rat_q[lrs1[i]];
         prs2[i]  = rat_q[lrs2[i]];
         pfree[i] = rat_q[lrd[i]];
         // Nearest older writer is checked last so it has priority
         for (int k = 0; k < i; k++)
         begin
            if (lrd_we[k] && (lrs1[i] == lrd[k]))
               prs1[i] = fl_prd[k];      // RAW on source 1
            if (lrd_we[k] && (lrs2[i] == lrd[k]))
               prs2[i] = fl_prd[k];      // RAW on source 2
            if (lrd_we[k] && lrd_we[i] && (lrd[i] == lrd[k]))
               pfree[i] = fl_prd[k];     // WAW, free the older slot's register
         end
      end
   end

endmodule

`default_nettype wire

//--- rn_ctrl.sv
// Rename controller sequencing run and recovery, and gating the rename group
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module rn_ctrl
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 flush,
   input  logic [`RN_IW-1:0]    rn_valid,
   input  logic [`RN_FL_AW:0]   fl_count,
   output logic                 rn_ready,
   output logic [`RN_IW-1:0]    rn_we,
   output logic                 rollback
);

   // A full group must be able to allocate
   localparam logic [`RN_FL_AW:0] MIN_FREE = `RN_IW;

   rn_pkg::ctrl_state_t state_q;
   rn_pkg::ctrl_state_t state_d;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         rn_pkg::RUN:
         begin
            if (flush)
               state_d = rn_pkg::RECOVER;
         end
         rn_pkg::RECOVER:
         begin
            // Another flush restarts the recovery
            state_d = flush ? rn_pkg::RECOVER : rn_pkg::RUN;
         end
         default:
         begin
            state_d = rn_pkg::RUN;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         state_q <= rn_pkg::RUN;
      else
         state_q <= state_d;
   end

   // Tables restore from the committed state while in RECOVER
   assign rollback = (state_q == rn_pkg::RECOVER);

   assign rn_ready = (state_q == rn_pkg::RUN) & ~flush & (fl_count >= MIN_FREE);
   assign rn_we    = rn_valid & {`RN_IW{rn_ready}};

endmodule

`default_nettype wire

//--- rn_ring_ptr.sv
// Wrap-around free-list pointer that advances by a variable step or loads a new value
`timescale 1ns/1ps
`default_nettype none

`include "rn_macros.svh"

module rn_ring_ptr
(
   input  logic                clk,
   input  logic                rst,
   input  logic [`RN_IW:0]     step,
   input  logic                load,
   input  rn_pkg::fl_ptr_t     load_value,
   output rn_pkg::fl_ptr_t     ptr
);

   // Pointer width covers the wrap bit, so the sum wraps naturally
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ptr <= '0;
      end
      else if (load)
      begin
         // Load wins over the step
         ptr <= load_value;
      end
      else
      begin
         ptr <= ptr + rn_pkg::fl_ptr_t'(step);
      end
   end

endmodule

`default_nettype wire

//--- rn_pkg.sv
// Register-index, pointer and controller-state types shared by the rename blocks
`default_nettype none

`include "rn_macros.svh"

package rn_pkg;

   // Logical register index
   typedef logic [`RN_LRF_AW-1:0] lreg_t;

   // Physical register index
   typedef logic [`RN_PRF_AW-1:0] preg_t;

   // Free-list pointer
   // Address plus a wrap bit so full and empty differ
   typedef logic [`RN_FL_AW:0] fl_ptr_t;

   // Rename controller states
   typedef enum logic
   {
      RUN     = 1'b0,
      RECOVER = 1'b1
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- rn_macros.svh
// Widths and slot counts for the register-rename stage
`ifndef RN_MACROS_SVH
`define RN_MACROS_SVH

// Rename slots per cycle
`define RN_IW 2

// Commit slots per cycle
`define RN_CW 2

// Logical register index width, 32 logical registers
`define RN_LRF_AW 5

// Physical register index width, 64 physical registers
`define RN_PRF_AW 6

// Free-list address width
// 32 entries, physical minus logical registers
`define RN_FL_AW 5

`endif
